/* bram.sv */
// True dual-port RAM in no-change mode, contents start at zero.
// Same-word accesses from both ports in one cycle are undefined.
`timescale 1ns/1ps
`default_nettype none

module bram (
    input  logic                       clk,
    input  logic                       rsta,
    input  spm_pkg::mem_port_t         port_a,
    input  spm_pkg::mem_port_t         port_b,
    output logic [spm_pkg::DATA_W-1:0] doa,
    output logic [spm_pkg::DATA_W-1:0] dob
);
    import spm_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH] = '{default: '0};
    logic [DATA_W-1:0] doa_q = '0;                   // Output latches power up cleared.
    logic [DATA_W-1:0] dob_q = '0;

    assign doa = doa_q;
    assign dob = dob_q;

    // Byte-lane writes of both ports.
    always_ff @(posedge clk) begin
        for (int i = 0; i < BYTES_W; i++) begin
            if (port_a.en && port_a.we[i]) begin
                mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
            end
            if (port_b.en && port_b.we[i]) begin
                mem[port_b.addr][8*i +: 8] <= port_b.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port_a.en) begin
            if (rsta) begin
                doa_q <= '0;
            end else if (port_a.we == '0) begin
                doa_q <= mem[port_a.addr];            // Latch holds during writes.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port_b.en) begin
            if (rsta) begin
                dob_q <= '0;
            end else if (port_b.we == '0) begin
                dob_q <= mem[port_b.addr];
            end
        end
    end

    a_no_dual_write: assert property (@(posedge clk) disable iff (rsta)
        !(port_a.en && (|port_a.we) && port_b.en && (|port_b.we)
          && (port_a.addr == port_b.addr)))
        else $error("bram: both ports write word %0d in one cycle", port_a.addr);

endmodule

`default_nettype wire

/* copy_engine.sv */
// Word block copy on RAM port B, ascending, one read and one write per word.
// A start while busy is ignored. Pointers wrap at the end of the RAM.
`timescale 1ns/1ps
`default_nettype none

module copy_engine (
    input  logic                       clk,
    input  logic                       rsta,
    input  logic                       start,
    input  spm_pkg::copy_cmd_t         cmd,
    output spm_pkg::mem_port_t         port_b,
    input  logic [spm_pkg::DATA_W-1:0] dob,
    output logic                       busy,
    output logic                       done
);
    import spm_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD,                                       // Read source word.
        ST_WR,                                       // Write it to the destination.
        ST_FIN
    } state_e;

    state_e             state;
    logic [WADDR_W-1:0] src;
    logic [WADDR_W-1:0] dst;
    logic [WADDR_W-1:0] remain;                      // Words left, incl. current one.

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (rsta) begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= (cmd.count == '0) ? ST_FIN : ST_RD;
                    end
                end
                ST_RD: begin
                    state <= ST_WR;
                end
                ST_WR: begin
                    state <= (remain == WADDR_W'(1)) ? ST_FIN : ST_RD;
                end
                ST_FIN: begin
                    state <= ST_IDLE;
                    done  <= 1'b1;                   // Same edge busy falls.
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && start) begin
            src    <= cmd.src;
            dst    <= cmd.dst;
            remain <= cmd.count;
        end else if (state == ST_WR) begin
            src    <= src + 1'b1;
            dst    <= dst + 1'b1;
            remain <= remain - 1'b1;
        end
    end

    // Read data comes from the port B latch, which no-change mode keeps stable.
    always_comb begin
        port_b.en    = (state == ST_RD) || (state == ST_WR);
        port_b.we    = (state == ST_WR) ? '1 : '0;
        port_b.addr  = (state == ST_WR) ? dst : src;
        port_b.wdata = dob;
    end

    // The word counter must be used up when the copy reports completion.
    a_done_ends_busy: assert property (@(posedge clk) disable iff (rsta)
        done |-> !busy && (remain == '0))
        else $error("copy_engine: done while busy or words remain");

    a_idle_quiet: assert property (@(posedge clk) disable iff (rsta)
        port_b.en |-> busy && (remain != '0))
        else $error("copy_engine: port B enabled while idle or with no words left");

endmodule

`default_nettype wire

/* lsu.sv */
// Load/store unit on RAM port A. Takes one request per cycle and never stalls.
// Misaligned requests make no memory access and only pulse misalign.
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  logic                       clk,
    input  logic                       rsta,
    input  logic                       req_valid,
    input  spm_pkg::lsu_req_t          req,
    output spm_pkg::mem_port_t         port_a,
    input  logic [spm_pkg::DATA_W-1:0] doa,
    output logic                       rsp_valid,
    output logic                       misalign,
    output logic [spm_pkg::DATA_W-1:0] rdata
);
    import spm_pkg::*;

    logic [$clog2(BYTES_W)-1:0] off;
    logic                       aligned;
    logic                       access;
    logic                       load;
    logic [BYTES_W-1:0]         size_mask;
    logic                       load_q;              // RAM latch holds the load word.
    logic [$clog2(BYTES_W)-1:0] off_q;
    size_e                      size_q;
    logic                       sext_q;
    logic [DATA_W-1:0]          lane_data;
    logic [DATA_W-1:0]          ext_data;

    assign off = req.addr[$clog2(BYTES_W)-1:0];

    // Alignment check and lane mask per size.
    always_comb begin
        aligned   = 1'b0;
        size_mask = '0;
        case (req.size)
            SZ_BYTE: begin
                aligned   = 1'b1;
                size_mask = BYTES_W'(1);
            end
            SZ_HALF: begin
                aligned   = (off[0] == 1'b0);
                size_mask = BYTES_W'(3);
            end
            SZ_WORD: begin
                aligned   = (off == '0);
                size_mask = '1;
            end
            default: aligned = 1'b0;                 // Unknown size is rejected.
        endcase
    end

    assign access = req_valid && aligned;
    assign load   = access && !req.store;

    always_comb begin
        port_a.en    = access;
        port_a.we    = req.store ? (size_mask << off) : '0;
        port_a.addr  = req.addr[BADDR_W-1:BADDR_W-WADDR_W];
        port_a.wdata = req.wdata << {off, 3'b000};   // Move data into its lanes.
    end

    always_ff @(posedge clk) begin
        if (rsta) begin
            load_q    <= 1'b0;
            rsp_valid <= 1'b0;
            misalign  <= 1'b0;
        end else begin
            load_q    <= load;
            rsp_valid <= load_q;
            misalign  <= req_valid && !aligned;
        end
    end

    // Load attributes follow the RAM read by one cycle.
    always_ff @(posedge clk) begin
        if (load) begin
            off_q  <= off;
            size_q <= req.size;
            sext_q <= req.sext;
        end
    end

    assign lane_data = doa >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            SZ_BYTE: ext_data = {{(DATA_W-8){sext_q & lane_data[7]}}, lane_data[7:0]};
            SZ_HALF: ext_data = {{(DATA_W-16){sext_q & lane_data[15]}}, lane_data[15:0]};
            default: ext_data = lane_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_q) begin
            rdata <= ext_data;
        end
    end

    // Every response must come from a read on port A.
    a_rsp_after_load: assert property (@(posedge clk) disable iff (rsta)
        rsp_valid |-> $past(port_a.en && (port_a.we == '0), 2))
        else $error("lsu: rsp_valid without a port A read two edges before");

endmodule

`default_nettype wire

/* scratchpad_top.sv */
// Scratchpad top. Adds no registers, latencies are those of lsu and copy_engine.
// Both ports accessing one word in the same cycle is undefined.
`timescale 1ns/1ps
`default_nettype none

module scratchpad_top (
    input  logic                       clk,
    input  logic                       rsta,
    input  logic                       req_valid,
    input  spm_pkg::lsu_req_t          req,
    output logic                       rsp_valid,
    output logic [spm_pkg::DATA_W-1:0] rdata,
    output logic                       misalign,
    input  logic                       start,
    input  spm_pkg::copy_cmd_t         cmd,
    output logic                       busy,
    output logic                       done
);
    import spm_pkg::*;

    mem_port_t         port_a;                       // Load/store side.
    mem_port_t         port_b;                       // Copy side.
    logic [DATA_W-1:0] doa;
    logic [DATA_W-1:0] dob;

    lsu u_lsu (
        .clk       (clk),
        .rsta      (rsta),
        .req_valid (req_valid),
        .req       (req),
        .port_a    (port_a),
        .doa       (doa),
        .rsp_valid (rsp_valid),
        .misalign  (misalign),
        .rdata     (rdata)
    );

    copy_engine u_copy (
        .clk    (clk),
        .rsta   (rsta),
        .start  (start),
        .cmd    (cmd),
        .port_b (port_b),
        .dob    (dob),
        .busy   (busy),
        .done   (done)
    );

    bram u_ram (
        .clk    (clk),
        .rsta   (rsta),
        .port_a (port_a),
        .port_b (port_b),
        .doa    (doa),
        .dob    (dob)
    );

endmodule

`default_nettype wire

/* spm_pkg.sv */
// Sizes and shared types of the 1 KiB scratchpad. Memory words are 32 bits.
// Requests and commands are plain structs. There is no handshake.
`default_nettype none

package spm_pkg;

    localparam int DATA_W  = 32;                     // Memory word width.
    localparam int BYTES_W = DATA_W / 8;             // Byte lanes per word.
    localparam int DEPTH   = 256;                    // Words in the RAM.
    localparam int WADDR_W = $clog2(DEPTH);          // Word address width.
    localparam int BADDR_W = WADDR_W + $clog2(BYTES_W);

    // Access size of a load/store request.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } size_e;

    typedef struct packed {
        logic [BADDR_W-1:0] addr;                    // Byte address.
        size_e              size;
        logic               store;
        logic               sext;                    // Loads only.
        logic [DATA_W-1:0]  wdata;                   // Right-aligned store data.
    } lsu_req_t;

    typedef struct packed {
        logic [WADDR_W-1:0] src;                     // Source word address.
        logic [WADDR_W-1:0] dst;                     // Destination word address.
        logic [WADDR_W-1:0] count;                   // Zero copies nothing.
    } copy_cmd_t;

    // One RAM port as seen by its master.
    typedef struct packed {
        logic               en;
        logic [BYTES_W-1:0] we;                      // Byte write enables.
        logic [WADDR_W-1:0] addr;
        logic [DATA_W-1:0]  wdata;
    } mem_port_t;

endpackage

`default_nettype wire

/* tb.f */
+incdir+.
spm_pkg.sv
bram.sv
lsu.sv
copy_engine.sv
scratchpad_top.sv
tb_scratchpad.sv

/* tb_util.svh */
// Galois LFSR and a byte-wide model of the scratchpad RAM, lanes are little-endian.
// Included in the testbench module after the spm_pkg import.

logic [31:0] lfsr = 32'h7c5a_2fe7;
logic [7:0]  model_mem [0:1023];

// One LFSR step per bit taken.
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r    = {r[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
endfunction

function automatic int size_bytes(input size_e size);
    return (size == SZ_BYTE) ? 1 : ((size == SZ_HALF) ? 2 : 4);
endfunction

function automatic logic is_aligned(input logic [BADDR_W-1:0] addr, input size_e size);
    return (addr % size_bytes(size)) == 0;
endfunction

task automatic model_clear();
    for (int i = 0; i < 1024; i++) begin
        model_mem[i] = 8'h00;
    end
endtask

task automatic model_store(input logic [BADDR_W-1:0] addr, input size_e size,
                           input logic [31:0] data);
    for (int i = 0; i < size_bytes(size); i++) begin
        model_mem[addr + i] = data[8*i +: 8];
    end
endtask

function automatic logic [31:0] model_load(input logic [BADDR_W-1:0] addr, input size_e size,
                                           input logic sext);
    int          n;
    logic [31:0] r;
    n = size_bytes(size);
    r = '0;
    for (int i = 0; i < n; i++) begin
        r[8*i +: 8] = model_mem[addr + i];
    end
    if (sext && r[8*n-1]) r = r | (32'hffff_ffff << (8 * n));  // Shift by 32 gives zero.
    return r;
endfunction

// Word by word in ascending order, so overlapping ranges smear like the hardware.
task automatic model_copy(input logic [WADDR_W-1:0] src, dst, cnt);
    logic [WADDR_W-1:0] s;
    logic [WADDR_W-1:0] d;
    for (int i = 0; i < cnt; i++) begin
        s = src + WADDR_W'(i);                      // Pointers wrap at the RAM end.
        d = dst + WADDR_W'(i);
        for (int b = 0; b < BYTES_W; b++) begin
            model_mem[{d, 2'b00} + b] = model_mem[{s, 2'b00} + b];
        end
    end
endtask

/* tb_scratchpad.sv */
// Random testbench for scratchpad_top with a byte model of the RAM.
// Never drives both ports at one word in the same cycle.
`timescale 1ns/1ps
`default_nettype none

module tb_scratchpad;
    import spm_pkg::*;

    localparam int N_INIT  = 32;
    localparam int N_RAND  = 400;
    localparam int N_MIS   = 24;
    localparam int N_COPY  = 12;
    localparam int N_BUSY  = 3;
    localparam int N_CONC  = 300;
    localparam int MAX_CNT = 31;
    // Worst case of all tests, doubled.
    localparam int CYCLE_LIMIT = 2 * (N_INIT + N_RAND + 2 * N_MIS + DEPTH
        + N_COPY * (3 * MAX_CNT + 6) + N_BUSY * (4 * MAX_CNT + 12)
        + N_CONC + 2 * MAX_CNT + DEPTH + 40) + 100;

    logic              clk = 1'b0;
    logic              rsta;
    logic              req_valid;
    lsu_req_t          req;
    logic              rsp_valid;
    logic [DATA_W-1:0] rdata;
    logic              misalign;
    logic              start;
    copy_cmd_t         cmd;
    logic              busy;
    logic              done;

    int cyc       = 0;                               // Falling edges after reset.
    int wd_cycles = 0;
    int checks    = 0;
    int errors    = 0;
    int tests     = 0;
    int test_err0 = 0;
    int busy_lo   = 0;                               // Expected busy window of the copy.
    int done_cyc  = 0;

    logic        next_rsp  = 1'b0;                   // Set by the request being driven.
    logic        next_mis  = 1'b0;
    logic [31:0] next_data = '0;
    logic        exp_rsp1  = 1'b0;                   // One edge after the drive.
    logic        exp_mis1  = 1'b0;
    logic [31:0] exp_data1 = '0;
    logic        exp_rsp2  = 1'b0;                   // Two edges after the drive.
    logic [31:0] exp_data2 = '0;

    `include "tb_util.svh"

    always #2 clk = ~clk;

    scratchpad_top uut (
        .clk       (clk),
        .rsta      (rsta),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rdata     (rdata),
        .misalign  (misalign),
        .start     (start),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done)
    );

    always @(posedge clk) begin
        wd_cycles++;
        if (wd_cycles > CYCLE_LIMIT) begin
            $display("Timeout after %0d clock cycles, the run did not complete", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    function automatic logic busy_due(input int c);
        return (c >= busy_lo) && (c < done_cyc);
    endfunction

    // Next falling edge, retire one stage of expectations and check all outputs.
    task automatic cycle();
        @(negedge clk);
        cyc++;
        req_valid = 1'b0;
        start     = 1'b0;
        exp_rsp2  = exp_rsp1;
        exp_data2 = exp_data1;
        exp_rsp1  = next_rsp;
        exp_data1 = next_data;
        exp_mis1  = next_mis;
        next_rsp  = 1'b0;
        next_mis  = 1'b0;
        compare("misalign", 32'(misalign), 32'(exp_mis1));
        compare("rsp_valid", 32'(rsp_valid), 32'(exp_rsp2));
        if (exp_rsp2) compare("rdata", rdata, exp_data2);
        compare("busy", 32'(busy), 32'(busy_due(cyc)));
        compare("done", 32'(done), 32'(cyc == done_cyc));
    endtask

    task automatic issue_req(input lsu_req_t r);
        req_valid = 1'b1;
        req       = r;
        if (!is_aligned(r.addr, r.size)) begin
            next_mis = 1'b1;
        end else if (r.store) begin
            model_store(r.addr, r.size, r.wdata);
        end else begin
            next_rsp  = 1'b1;
            next_data = model_load(r.addr, r.size, r.sext);
        end
    endtask

    task automatic issue_start(input copy_cmd_t c);
        start = 1'b1;
        cmd   = c;
        if (!busy_due(cyc)) begin                    // Ignored while a copy runs.
            model_copy(c.src, c.dst, c.count);
            busy_lo  = cyc + 1;
            done_cyc = cyc + 2 * int'(c.count) + 2;
        end
    endtask

    // Aligned request with a byte address of abits random bits.
    function automatic lsu_req_t rand_req(input int abits);
        lsu_req_t r;
        r.size  = size_e'(rand_bits(2) % 3);
        r.store = 1'(rand_bits(1));
        r.sext  = 1'(rand_bits(1));
        r.wdata = rand_bits(32);
        r.addr  = BADDR_W'(rand_bits(abits));
        if (r.size == SZ_HALF) r.addr[0] = 1'b0;
        if (r.size == SZ_WORD) r.addr[1:0] = 2'b00;
        return r;
    endfunction

    task automatic access_word(input logic [WADDR_W-1:0] w, input logic store);
        lsu_req_t r;
        r       = '0;
        r.addr  = {w, 2'b00};
        r.size  = SZ_WORD;
        r.store = store;
        r.wdata = store ? rand_bits(32) : '0;
        issue_req(r);
        cycle();
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        copy_cmd_t c;
        copy_cmd_t c2;
        lsu_req_t  r;
        rsta      = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        start     = 1'b0;
        cmd       = '0;
        model_clear();
        repeat (3) @(negedge clk);
        rsta = 1'b0;

        cycle();
        for (int i = 0; i < N_INIT; i++) access_word(WADDR_W'(rand_bits(WADDR_W)), 1'b0);
        repeat (2) cycle();
        end_test("reset state");

        for (int i = 0; i < N_RAND; i++) begin
            issue_req(rand_req(7));                  // Small window so loads hit stores.
            cycle();
        end
        repeat (2) cycle();
        end_test("random stores and loads");

        for (int i = 0; i < N_MIS; i++) begin
            r = rand_req(7);
            if (rand_bits(1)) begin
                r.size    = SZ_HALF;
                r.addr[0] = 1'b1;
            end else begin
                r.size      = SZ_WORD;
                r.addr[1:0] = 2'(1 + rand_bits(2) % 3);
            end
            issue_req(r);
            cycle();
            access_word(r.addr[BADDR_W-1:2], 1'b0);
        end
        repeat (2) cycle();
        end_test("misaligned requests");

        for (int w = 0; w < DEPTH; w++) access_word(WADDR_W'(w), 1'b1);
        for (int i = 0; i < N_COPY; i++) begin
            c.src   = WADDR_W'(rand_bits(8));
            c.dst   = rand_bits(1) ? c.src + WADDR_W'(rand_bits(3)) - WADDR_W'(4)
                                   : WADDR_W'(rand_bits(8));
            c.count = (i == 0) ? '0 : WADDR_W'(rand_bits(5));
            issue_start(c);
            cycle();
            while (!done) cycle();
            for (int j = 0; j < c.count; j++) access_word(WADDR_W'(c.dst + j), 1'b0);
            repeat (2) cycle();
        end
        end_test("random copies");

        for (int i = 0; i < N_BUSY; i++) begin
            c.src    = WADDR_W'(rand_bits(8));
            c.dst    = WADDR_W'(rand_bits(8));
            c.count  = WADDR_W'(8 + rand_bits(4));
            c2.src   = WADDR_W'(rand_bits(8));
            c2.dst   = WADDR_W'(rand_bits(8));
            c2.count = WADDR_W'(1 + rand_bits(4));
            issue_start(c);
            cycle();
            repeat (1 + rand_bits(2)) cycle();
            issue_start(c2);
            cycle();
            while (!done) cycle();
            for (int j = 0; j < c.count; j++) access_word(WADDR_W'(c.dst + j), 1'b0);
            for (int j = 0; j < c2.count; j++) access_word(WADDR_W'(c2.dst + j), 1'b0);
            repeat (2) cycle();
        end
        end_test("start while busy");

        for (int i = 0; i < N_CONC; i++) begin
            if (!busy_due(cyc) && rand_bits(1)) begin
                c.src   = 8'd128 + WADDR_W'(rand_bits(6));  // Upper half only.
                c.dst   = 8'd128 + WADDR_W'(rand_bits(6));
                c.count = WADDR_W'(rand_bits(4));
                issue_start(c);
            end
            if (rand_bits(2) != 0) issue_req(rand_req(9));
            cycle();
        end
        while (busy) cycle();
        for (int w = 0; w < DEPTH; w++) access_word(WADDR_W'(w), 1'b0);
        repeat (2) cycle();
        end_test("ports running together");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
